// ==== common/transfer_counter_pkg.sv ====
package transfer_counter_pkg;

    // step applied to the in-flight count in one cycle.
    typedef enum logic [1:0] {
        STEP_NONE = 2'b00,
        STEP_INC  = 2'b01,
        STEP_DEC  = 2'b10,
        // entry and exit in the same cycle cancel.
        STEP_HOLD = 2'b11
    } count_step_e;

    // report emitter states.
    typedef enum logic [0:0] {
        REPORT_IDLE = 1'b0,
        REPORT_SEND = 1'b1
    } report_state_e;

    // bits needed to hold 0 up to max_value.
    function automatic int count_width(int max_value);
        int width;
        width = $clog2(max_value + 1);
        if (width < 1) begin
            width = 1;
        end
        return width;
    endfunction

endpackage

// ==== rtl/transfer_qualifier.sv ====
`timescale 1ns/1ns

module transfer_qualifier #(
    int PACKETS = 0
) (
    input  logic                              monitor_rx_tvalid,
    input  logic                              monitor_rx_tready,
    input  logic                              monitor_rx_tlast,
    input  logic                              monitor_tx_tvalid,
    input  logic                              monitor_tx_tready,
    input  logic                              monitor_tx_tlast,
    output transfer_counter_pkg::count_step_e step
);
    import transfer_counter_pkg::*;

    // in packet mode only the closing beat of a packet counts.
    localparam bit COUNT_LAST_ONLY = (PACKETS != 0);

    logic rx_handshake;
    logic tx_handshake;
    logic rx_beat;
    logic tx_beat;

    assign rx_handshake = monitor_rx_tvalid && monitor_rx_tready;
    assign tx_handshake = monitor_tx_tvalid && monitor_tx_tready;

    assign rx_beat = rx_handshake && (!COUNT_LAST_ONLY || monitor_rx_tlast);
    assign tx_beat = tx_handshake && (!COUNT_LAST_ONLY || monitor_tx_tlast);

    // one opcode per cycle for the count core.
    always_comb begin
        case ({rx_beat, tx_beat})
            2'b10: begin
                step = STEP_INC;
            end
            2'b01: begin
                step = STEP_DEC;
            end
            2'b11: begin
                step = STEP_HOLD;
            end
            default: begin
                step = STEP_NONE;
            end
        endcase
    end

endmodule

// ==== rtl/transfer_count_core.sv ====
`timescale 1ns/1ns

module transfer_count_core #(
    int COUNTER_MAX = 256
) (
    input  logic                                                        aclk,
    input  logic                                                        arst_n,
    input  transfer_counter_pkg::count_step_e                           step,
    output logic [transfer_counter_pkg::count_width(COUNTER_MAX)-1:0] count
);
    import transfer_counter_pkg::*;

    localparam int COUNT_W = count_width(COUNTER_MAX);
    localparam logic [COUNT_W-1:0] COUNT_LIMIT = COUNT_W'(COUNTER_MAX);

    logic at_limit;
    logic at_floor;

    assign at_limit = (count == COUNT_LIMIT);
    assign at_floor = (count == '0);

    // in-flight count, saturating at the top and floored at zero.
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case (step)
                STEP_INC: begin
                    if (!at_limit) begin
                        count <= count + 1'b1;
                    end
                end
                STEP_DEC: begin
                    if (!at_floor) begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    // no step or balanced step.
                    count <= count;
                end
            endcase
        end
    end

endmodule

// ==== rtl/count_report_tx.sv ====
`timescale 1ns/1ns

module count_report_tx #(
    int COUNTER_MAX = 256,
    int TDATA_BYTES = 4
) (
    input  logic                                                        aclk,
    input  logic                                                        arst_n,
    input  logic [transfer_counter_pkg::count_width(COUNTER_MAX)-1:0] count,
    input  logic                                                        tx_tready,
    output logic                                                        tx_tvalid,
    output logic [TDATA_BYTES-1:0][7:0]                                 tx_tdata
);
    import transfer_counter_pkg::*;

    localparam int COUNT_W = count_width(COUNTER_MAX);

    if (TDATA_BYTES * 8 < COUNT_W) begin : g_width_check
        $error("tdata is too narrow for the count");
    end

    report_state_e        state;
    logic [COUNT_W-1:0]   last_sent;
    logic [COUNT_W-1:0]   held_count;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= REPORT_IDLE;
            last_sent  <= '0;
            held_count <= '0;
        end else begin
            case (state)
                REPORT_IDLE: begin
                    if (count != last_sent) begin
                        held_count <= count;
                        state      <= REPORT_SEND;
                    end
                end
                REPORT_SEND: begin
                    if (tx_tready) begin
                        last_sent <= held_count;
                        // a newer count goes out back to back.
                        if (count != held_count) begin
                            held_count <= count;
                        end else begin
                            state <= REPORT_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    assign tx_tvalid = (state == REPORT_SEND);
    assign tx_tdata  = (TDATA_BYTES * 8)'(held_count);

endmodule

// ==== rtl/transfer_counter_top.sv ====
`timescale 1ns/1ns

module transfer_counter_top #(
    int COUNTER_MAX = 256,
    int PACKETS = 0,
    int TDATA_BYTES = 4
) (
    input  logic                        aclk,
    input  logic                        arst_n,
    // receive point monitor.
    input  logic                        monitor_rx_tvalid,
    input  logic                        monitor_rx_tready,
    input  logic                        monitor_rx_tlast,
    // transmit point monitor.
    input  logic                        monitor_tx_tvalid,
    input  logic                        monitor_tx_tready,
    input  logic                        monitor_tx_tlast,
    // count report stream.
    output logic                        tx_tvalid,
    output logic [TDATA_BYTES-1:0][7:0] tx_tdata,
    output logic                        tx_tlast,
    output logic [TDATA_BYTES-1:0]      tx_tstrb,
    output logic [TDATA_BYTES-1:0]      tx_tkeep,
    input  logic                        tx_tready
);
    import transfer_counter_pkg::*;

    localparam int COUNT_W = count_width(COUNTER_MAX);

    count_step_e        step;
    logic [COUNT_W-1:0] count;

    // decode both monitor handshakes into one step.
    transfer_qualifier #(
        .PACKETS(PACKETS)
    ) i_transfer_qualifier (
        .monitor_rx_tvalid(monitor_rx_tvalid),
        .monitor_rx_tready(monitor_rx_tready),
        .monitor_rx_tlast (monitor_rx_tlast),
        .monitor_tx_tvalid(monitor_tx_tvalid),
        .monitor_tx_tready(monitor_tx_tready),
        .monitor_tx_tlast (monitor_tx_tlast),
        .step             (step)
    );

    // in-flight count register.
    transfer_count_core #(
        .COUNTER_MAX(COUNTER_MAX)
    ) i_transfer_count_core (
        .aclk  (aclk),
        .arst_n(arst_n),
        .step  (step),
        .count (count)
    );

    // report each changed count.
    count_report_tx #(
        .COUNTER_MAX(COUNTER_MAX),
        .TDATA_BYTES(TDATA_BYTES)
    ) i_count_report_tx (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .count    (count),
        .tx_tready(tx_tready),
        .tx_tvalid(tx_tvalid),
        .tx_tdata (tx_tdata)
    );

    // every report is one complete beat with all bytes valid.
    assign tx_tlast = 1'b1;
    assign tx_tstrb = '1;
    assign tx_tkeep = '1;

endmodule

// ==== tests/transfer_counter_asserts.sv ====
`timescale 1ns/1ns

module transfer_counter_asserts #(
    int COUNTER_MAX = 256,
    int TDATA_BYTES = 4
) (
    input logic                        aclk,
    input logic                        arst_n,
    input logic                        tx_tvalid,
    input logic                        tx_tready,
    input logic [TDATA_BYTES-1:0][7:0] tx_tdata,
    input logic                        tx_tlast,
    input logic [TDATA_BYTES-1:0]      tx_tstrb,
    input logic [TDATA_BYTES-1:0]      tx_tkeep
);
    import transfer_counter_pkg::*;

    // failures so far, polled by the testbench.
    int failure_count = 0;

    report_state_e tx_phase;

    // emitter phase as seen from the stream side.
    assign tx_phase = tx_tvalid ? REPORT_SEND : REPORT_IDLE;

    reset_quiet_a: assert property (@(posedge aclk) !arst_n |-> !tx_tvalid)
        else begin
            $error("tx_tvalid high while arst_n is low");
            failure_count++;
        end

    reset_exit_quiet_a: assert property (@(posedge aclk) !arst_n |=> !tx_tvalid)
        else begin
            $error("tx_tvalid high in the first cycle after reset");
            failure_count++;
        end

    // a stalled beat keeps valid and data until accepted.
    stall_stable_a: assert property (@(posedge aclk) disable iff (!arst_n)
        (tx_phase == REPORT_SEND && !tx_tready) |=> (tx_tvalid && $stable(tx_tdata)))
        else begin
            $error("tx beat changed while stalled");
            failure_count++;
        end

    data_range_a: assert property (@(posedge aclk)
        tx_tdata <= (TDATA_BYTES * 8)'(COUNTER_MAX))
        else begin
            $error("tx_tdata above the counter limit");
            failure_count++;
        end

    last_high_a: assert property (@(posedge aclk) tx_tlast)
        else begin
            $error("tx_tlast is low");
            failure_count++;
        end

    // every report marks all bytes valid.
    all_bytes_a: assert property (@(posedge aclk) (&tx_tstrb) && (&tx_tkeep))
        else begin
            $error("tx_tstrb or tx_tkeep not all ones");
            failure_count++;
        end

endmodule

// ==== tests/transfer_counter_tb.sv ====
`timescale 1ns/1ns

module transfer_counter_tb #(
    int PACKETS = 0
);
    localparam int COUNTER_MAX    = 15;
    localparam int TDATA_BYTES    = 4;
    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 5;
    localparam int RESET_CYCLES   = 10;
    localparam int IDLE_CYCLES    = 10;
    localparam int TRAFFIC_CYCLES = 300;
    localparam int RUN_CYCLES     = 40;
    // reset, quiet check, two traffic phases and two runs, each with its idle tail.
    localparam int TEST_CYCLES = RESET_CYCLES + 2 * IDLE_CYCLES
                               + 2 * (TRAFFIC_CYCLES + IDLE_CYCLES)
                               + 2 * (RUN_CYCLES + IDLE_CYCLES);
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 500;

    logic                        aclk;
    logic                        arst_n;
    logic                        monitor_rx_tvalid;
    logic                        monitor_rx_tready;
    logic                        monitor_rx_tlast;
    logic                        monitor_tx_tvalid;
    logic                        monitor_tx_tready;
    logic                        monitor_tx_tlast;
    logic                        tx_tready;
    logic                        tx_tvalid;
    logic [TDATA_BYTES-1:0][7:0] tx_tdata;
    logic                        tx_tlast;
    logic [TDATA_BYTES-1:0]      tx_tstrb;
    logic [TDATA_BYTES-1:0]      tx_tkeep;

    integer seed = 32'ha7d3_7d33;
    int     model_count = 0;
    int     last_report = 0;
    int     report_beats = 0;
    int     cycle_count = 0;

    transfer_counter_top #(
        .COUNTER_MAX(COUNTER_MAX),
        .PACKETS    (PACKETS),
        .TDATA_BYTES(TDATA_BYTES)
    ) i_transfer_counter_top (
        .aclk             (aclk),
        .arst_n           (arst_n),
        .monitor_rx_tvalid(monitor_rx_tvalid),
        .monitor_rx_tready(monitor_rx_tready),
        .monitor_rx_tlast (monitor_rx_tlast),
        .monitor_tx_tvalid(monitor_tx_tvalid),
        .monitor_tx_tready(monitor_tx_tready),
        .monitor_tx_tlast (monitor_tx_tlast),
        .tx_tvalid        (tx_tvalid),
        .tx_tdata         (tx_tdata),
        .tx_tlast         (tx_tlast),
        .tx_tstrb         (tx_tstrb),
        .tx_tkeep         (tx_tkeep),
        .tx_tready        (tx_tready)
    );

    bind transfer_counter_top transfer_counter_asserts #(
        .COUNTER_MAX(COUNTER_MAX),
        .TDATA_BYTES(TDATA_BYTES)
    ) i_transfer_counter_asserts (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .tx_tvalid(tx_tvalid),
        .tx_tready(tx_tready),
        .tx_tdata (tx_tdata),
        .tx_tlast (tx_tlast),
        .tx_tstrb (tx_tstrb),
        .tx_tkeep (tx_tkeep)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) aclk = ~aclk;
        end
    end

    task automatic fail_run();
        $display("test failed");
        $fatal(1);
    endtask

    function automatic bit percent_hit(input int pct);
        int draw;
        draw = $unsigned($random(seed)) % 100;
        return (draw < pct);
    endfunction

    // reference count steps up on entry and down on exit within 0 to 15.
    function automatic int next_count(input int current, input bit rx_in, input bit tx_out);
        if (rx_in && !tx_out && current < COUNTER_MAX) begin
            return current + 1;
        end
        if (tx_out && !rx_in && current > 0) begin
            return current - 1;
        end
        return current;
    endfunction

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            fail_run();
        end
    end

    // inputs are stable here and hold until the next rising edge.
    always @(negedge aclk) begin
        bit rx_counts;
        bit tx_counts;
        rx_counts = monitor_rx_tvalid && monitor_rx_tready && (PACKETS == 0 || monitor_rx_tlast);
        tx_counts = monitor_tx_tvalid && monitor_tx_tready && (PACKETS == 0 || monitor_tx_tlast);
        if (!arst_n) begin
            model_count = 0;
            last_report = 0;
        end else begin
            if (tx_tvalid && tx_tready) begin
                last_report  = int'(tx_tdata);
                report_beats = report_beats + 1;
            end
            model_count = next_count(model_count, rx_counts, tx_counts);
        end
        assert (i_transfer_counter_top.i_transfer_counter_asserts.failure_count == 0)
        else begin
            $display("a tx protocol assertion failed");
            fail_run();
        end
    end

    task automatic drive_traffic(input int cycles, input int rx_pct, input int tx_pct,
                                 input int ready_pct, input bit force_last);
        repeat (cycles) begin
            @(posedge aclk);
            #(DRIVE_DELAY);
            monitor_rx_tvalid = percent_hit(rx_pct);
            monitor_rx_tready = percent_hit(80);
            monitor_rx_tlast  = force_last || percent_hit(40);
            monitor_tx_tvalid = percent_hit(tx_pct);
            monitor_tx_tready = percent_hit(80);
            monitor_tx_tlast  = force_last || percent_hit(40);
            tx_tready         = percent_hit(ready_pct);
        end
    endtask

    task automatic idle_monitors(input int cycles, input bit expect_quiet);
        repeat (cycles) begin
            @(posedge aclk);
            #(DRIVE_DELAY);
            monitor_rx_tvalid = 1'b0;
            monitor_tx_tvalid = 1'b0;
            tx_tready         = 1'b1;
            if (expect_quiet) begin
                assert (!tx_tvalid) else begin
                    $display("tx beat raised with idle monitors after reset");
                    fail_run();
                end
            end
        end
    endtask

    task automatic settle_and_check(input string phase, input int expected);
        idle_monitors(IDLE_CYCLES, 1'b0);
        assert (!tx_tvalid) else begin
            $display("tx beat still pending after the %s phase", phase);
            fail_run();
        end
        assert (last_report == expected) else begin
            $display("ERR %0t tx_tdata got %0d expected %0d (%s)",
                     $time, last_report, expected, phase);
            fail_run();
        end
    endtask

    initial begin
        arst_n            = 1'b0;
        monitor_rx_tvalid = 1'b0;
        monitor_rx_tready = 1'b0;
        monitor_rx_tlast  = 1'b0;
        monitor_tx_tvalid = 1'b0;
        monitor_tx_tready = 1'b0;
        monitor_tx_tlast  = 1'b0;
        tx_tready         = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #(DRIVE_DELAY);
        arst_n = 1'b1;

        idle_monitors(2 * IDLE_CYCLES, 1'b1);
        assert (report_beats == 0) else begin
            $display("tx beat accepted with idle monitors after reset");
            fail_run();
        end

        // rx slightly ahead of tx.
        drive_traffic(TRAFFIC_CYCLES, 60, 50, 100, 1'b0);
        settle_and_check("balanced", model_count);

        drive_traffic(RUN_CYCLES, 90, 0, 100, 1'b1);
        assert (model_count == COUNTER_MAX) else begin
            $display("saturation run did not reach the limit");
            fail_run();
        end
        settle_and_check("saturation", COUNTER_MAX);

        drive_traffic(RUN_CYCLES, 0, 90, 100, 1'b1);
        settle_and_check("floor", 0);

        // tx stalls often while the count moves.
        drive_traffic(TRAFFIC_CYCLES, 55, 45, 35, 1'b0);
        settle_and_check("back-pressure", model_count);

        if (i_transfer_counter_top.i_transfer_counter_asserts.failure_count != 0) begin
            $display("a tx protocol assertion failed");
            fail_run();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== project.f ====
common/transfer_counter_pkg.sv
rtl/transfer_qualifier.sv
rtl/transfer_count_core.sv
rtl/count_report_tx.sv
rtl/transfer_counter_top.sv
tests/transfer_counter_asserts.sv
tests/transfer_counter_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := transfer_counter_tb
FILELIST  := project.f
RUNFLAGS  := +verilator+error+limit+100
PASS_MSG  := test passed

# build and run one PACKETS setting; pass only if the pass line shows up.
define run_sim
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GPACKETS=$(1) --Mdir obj_packets$(1) \
		-f $(FILELIST)
	@out="$$(./obj_packets$(1)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"
endef

.PHONY: all lint sim sim_streams sim_packets clean

all: lint sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim: sim_streams sim_packets

sim_streams:
	$(call run_sim,0)

sim_packets:
	$(call run_sim,1)

clean:
	rm -rf obj_packets0 obj_packets1
